// File: poolPkg.sv
// Max pooling shared types
`default_nettype none

package poolPkg;

    // ========================================
    // Sizes
    // ========================================

    // Channels per feature vector
    localparam int NUM_CHANNELS = 8;

    // Bits per channel value
    // Values are unsigned
    localparam int DATA_W = 8;

    // ========================================
    // Payload types
    // ========================================

    // One feature vector
    // Channel 0 sits in the low bits
    typedef struct packed {
        logic [NUM_CHANNELS-1:0][DATA_W-1:0] ch;
    } featVec_t;

    // Input beat
    // last closes the current window
    typedef struct packed {
        featVec_t data;
        logic     last;
    } inBeat_t;

    // ========================================
    // Core state
    // ========================================

    // IDLE only lasts one cycle after reset
    // ACCUM takes beats and folds them into the maxima
    // EMIT offers the pooled vector downstream
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ACCUM = 2'd1,
        EMIT  = 2'd2
    } poolState_t;

endpackage

`default_nettype wire

// File: maxPoolCore.sv
// Window max pooling core
`timescale 1ns/1ps
`default_nettype none

module maxPoolCore
    import poolPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Upstream feature beats
    input  logic     inValid,
    input  inBeat_t  inBeat,
    output logic     inReady,
    // Pooled vector towards the output buffer
    output logic     outValid,
    output featVec_t outVec,
    input  logic     outReady
);

    // ========================================
    // Declarations
    // ========================================

    // Pooling FSM
    poolState_t state;
    poolState_t nextState;

    // Handshake events
    logic beatAccept;
    logic lastAccept;
    logic emitDone;

    // Start of a fresh window
    logic clearMax;

    // ========================================
    // Handshakes
    // ========================================

    // Beat taken this edge
    // inReady already implies ACCUM
    assign beatAccept = inValid && inReady;

    // Window closes on this edge
    assign lastAccept = beatAccept && inBeat.last;

    // Pooled vector leaves on this edge
    assign emitDone = outValid && outReady;

    // Zero the maxima right after reset and after each emit
    // Zero is the smallest unsigned value so any beat wins
    assign clearMax = (state == IDLE) || emitDone;

    // Control outputs come from the state alone
    assign inReady  = (state == ACCUM);
    assign outValid = (state == EMIT);

    // ========================================
    // FSM
    // ========================================

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                // Leave idle on the first cycle after reset
                nextState = ACCUM;
            end
            ACCUM: begin
                if (lastAccept) begin
                    nextState = EMIT;
                end
            end
            EMIT: begin
                // Hold the result until the buffer takes it
                if (emitDone) begin
                    nextState = ACCUM;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // ========================================
    // Per-channel running maximum
    // ========================================

    genvar g;
    generate
        for (g = 0; g < NUM_CHANNELS; g++) begin : gChan
            // Incoming value of this channel
            logic [DATA_W-1:0] inVal;
            // Running maximum of this channel
            logic [DATA_W-1:0] maxQ;

            assign inVal = inBeat.data.ch[g];

            // Clear wins over update
            // Both never meet since clears happen outside ACCUM beats
            always_ff @(posedge clk) begin
                if (clearMax) begin
                    maxQ <= '0;
                end else if (beatAccept && (inVal > maxQ)) begin
                    maxQ <= inVal;
                end
            end

            // Stays steady through EMIT as no beat is accepted there
            assign outVec.ch[g] = maxQ;
        end
    endgenerate

endmodule

`default_nettype wire

// File: pooledSkidBuffer.sv
// Two-entry pooled result buffer
`timescale 1ns/1ps
`default_nettype none

module pooledSkidBuffer
    import poolPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // From the pooling core
    input  logic     inValid,
    input  featVec_t inVec,
    output logic     inReady,
    // Towards downstream
    output logic     outValid,
    output featVec_t outVec,
    input  logic     outReady
);

    // ========================================
    // Storage and pointers
    // ========================================

    // Result slots
    featVec_t entry [2];

    // Oldest slot
    logic       head;
    // Slots in use, 0 to 2
    logic [1:0] count;
    // Slot for the next push
    logic       wrIdx;

    logic push;
    logic pop;

    // Accept while a slot is free
    assign inReady  = (count != 2'd2);
    assign outValid = (count != 2'd0);

    // Head slot goes out straight from the registers
    assign outVec = entry[head];

    assign push = inValid && inReady;
    assign pop  = outValid && outReady;

    // Next free slot sits behind the head
    // Only used with count below two
    assign wrIdx = head ^ count[0];

    // Payload slots
    always_ff @(posedge clk) begin
        if (push) begin
            entry[wrIdx] <= inVec;
        end
    end

    // ========================================
    // Occupancy
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= 1'b0;
            count <= 2'd0;
        end else begin
            if (pop) begin
                head <= ~head;
            end
            // Push with pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: maxPoolTop.sv
// Max pooling top level
`timescale 1ns/1ps
`default_nettype none

module maxPoolTop
    import poolPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Feature beat stream
    input  logic     inValid,
    input  inBeat_t  inBeat,
    output logic     inReady,
    // Pooled vector stream
    output logic     outValid,
    output featVec_t outVec,
    input  logic     outReady
);

    // ========================================
    // Core to buffer link
    // ========================================

    logic     coreValid;
    featVec_t coreVec;
    logic     coreReady;

    // Running maximum and window FSM
    maxPoolCore i_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (inValid),
        .inBeat   (inBeat),
        .inReady  (inReady),
        .outValid (coreValid),
        .outVec   (coreVec),
        .outReady (coreReady)
    );

    // Holds up to two finished windows
    // Lets the core start the next window under a stall
    pooledSkidBuffer i_outBuf (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (coreValid),
        .inVec    (coreVec),
        .inReady  (coreReady),
        .outValid (outValid),
        .outVec   (outVec),
        .outReady (outReady)
    );

endmodule

`default_nettype wire

// File: maxPool_properties.sv
// Max pooling handshake assertions
`timescale 1ns/1ps
`default_nettype none

module maxPool_properties
    import poolPkg::*;
(
    input logic     clk,
    input logic     rst_n,
    // Feature beat stream
    input logic     inValid,
    input inBeat_t  inBeat,
    input logic     inReady,
    // Core to buffer link
    input logic     coreValid,
    input featVec_t coreVec,
    input logic     coreReady,
    // Pooled vector stream
    input logic     outValid,
    input featVec_t outVec,
    input logic     outReady
);

    // ========================================
    // Stalled senders hold their payload
    // ========================================

    // Upstream beat under back-pressure from the core
    inHold: assert property (@(posedge clk) disable iff (!rst_n)
        (inValid && !inReady) |=> (inValid && $stable(inBeat)))
        else $error("input beat dropped or changed while stalled");

    // Core result waiting on a full buffer
    coreHold: assert property (@(posedge clk) disable iff (!rst_n)
        (coreValid && !coreReady) |=> (coreValid && $stable(coreVec)))
        else $error("core result dropped or changed while stalled");

    // Buffer head waiting on downstream
    outHold: assert property (@(posedge clk) disable iff (!rst_n)
        (outValid && !outReady) |=> (outValid && $stable(outVec)))
        else $error("pooled output dropped or changed while stalled");

    // ========================================
    // Window close stops the input
    // ========================================

    // Last beat taken means the result is offered next cycle
    // and no further beat is taken meanwhile
    lastBlocksInput: assert property (@(posedge clk) disable iff (!rst_n)
        (inValid && inReady && inBeat.last) |=> (coreValid && !inReady))
        else $error("core keeps taking beats after the window closed");

endmodule

// Attach to every top level instance
bind maxPoolTop maxPool_properties i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .inValid   (inValid),
    .inBeat    (inBeat),
    .inReady   (inReady),
    .coreValid (coreValid),
    .coreVec   (coreVec),
    .coreReady (coreReady),
    .outValid  (outValid),
    .outVec    (outVec),
    .outReady  (outReady)
);

`default_nettype wire

// File: tbMaxPool.sv
// Max pooling testbench
`timescale 1ns/1ps
`default_nettype none

module tbMaxPool
    import poolPkg::*;
();

    // ========================================
    // Table and limits
    // ========================================

    localparam int NUM_FIXED  = 5;
    localparam int NUM_RAND   = 12;
    localparam int NUM_WIN    = NUM_FIXED + NUM_RAND;
    localparam int MAX_BEATS  = 6;
    localparam int TIMEOUT    = 200;
    localparam int RESET_WAIT = 8;
    localparam logic [31:0] SEED = 32'h1f59131b;

    // One window: back-pressure flag, beat count, beats
    typedef struct packed {
        logic                        stall;
        logic [3:0]                  beats;
        featVec_t [MAX_BEATS-1:0]    vec;
    } winRow_t;

    logic     clk;
    logic     rst_n;
    logic     inValid;
    inBeat_t  inBeat;
    logic     inReady;
    logic     outValid;
    featVec_t outVec;
    logic     outReady;

    winRow_t     winTable [NUM_WIN];
    // Edge that took the last beat of each window
    int          lastEdge [NUM_WIN];
    featVec_t    expQ [$];
    int          edgeCount = 0;
    int          errorCount = 0;
    int          testsRun = 0;
    int          testsBad = 0;
    logic        timedOut = 1'b0;
    // Separate streams for input gaps and output back-pressure
    logic [31:0] rngIn;
    logic [31:0] rngOut;

    maxPoolTop i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (inValid),
        .inBeat   (inBeat),
        .inReady  (inReady),
        .outValid (outValid),
        .outVec   (outVec),
        .outReady (outReady)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) edgeCount <= edgeCount + 1;

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Per-channel maximum over the beats of one window
    function automatic featVec_t maxOfWindow(input winRow_t row);
        featVec_t m;
        m = '0;
        for (int b = 0; b < int'(row.beats); b++) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (row.vec[b].ch[c] > m.ch[c]) begin
                    m.ch[c] = row.vec[b].ch[c];
                end
            end
        end
        return m;
    endfunction

    task automatic checkVec(input string name, input featVec_t exp, input featVec_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkLogic(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkCycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        if (errorCount != errBefore) begin
            testsBad++;
            $display("test %s: %0d errors", name, errorCount - errBefore);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ========================================
    // Window table
    // ========================================

    task automatic buildTable();
        winRow_t     row;
        logic [31:0] hi;
        // Single beat passes straight through
        row = '0;
        row.beats = 4'd1;
        row.vec[0] = featVec_t'(64'h8877665544332211);
        winTable[0] = row;
        // Channel maxima spread over three beats
        row = '0;
        row.beats = 4'd3;
        row.vec[0] = featVec_t'(64'h10E02005C10311F5);
        row.vec[1] = featVec_t'(64'h9A0E01B74002D200);
        row.vec[2] = featVec_t'(64'h33707C4400FF0C80);
        winTable[1] = row;
        // Large values, then small ones to catch a missing clear
        row = '0;
        row.beats = 4'd2;
        row.vec[0] = featVec_t'(64'hFEFDFCFBFAF9F8F7);
        row.vec[1] = featVec_t'(64'hF0F1F2F3F4F5F6FF);
        winTable[2] = row;
        row.vec[0] = featVec_t'(64'h0102030405060708);
        row.vec[1] = featVec_t'(64'h0807060504030201);
        winTable[3] = row;
        // All zero window
        row = '0;
        row.beats = 4'd1;
        winTable[4] = row;
        // Random windows under back-pressure
        for (int w = NUM_FIXED; w < NUM_WIN; w++) begin
            row = '0;
            row.stall = 1'b1;
            rngIn = xorshift32(rngIn);
            row.beats = 4'(1 + rngIn % MAX_BEATS);
            for (int b = 0; b < MAX_BEATS; b++) begin
                rngIn = xorshift32(rngIn);
                hi = rngIn;
                rngIn = xorshift32(rngIn);
                row.vec[b] = featVec_t'({hi, rngIn});
            end
            winTable[w] = row;
        end
    endtask

    // ========================================
    // Input and output sides
    // ========================================

    task automatic driveWindows();
        winRow_t row;
        int      nBeats;
        int      waitCycles;
        logic    accepted;
        for (int w = 0; w < NUM_WIN; w++) begin
            row = winTable[w];
            nBeats = int'(row.beats);
            for (int b = 0; b < nBeats; b++) begin
                rngIn = xorshift32(rngIn);
                // Occasional idle cycle between beats
                if (row.stall && rngIn[0]) begin
                    inValid = 1'b0;
                    @(posedge clk);
                    #1;
                end
                inValid = 1'b1;
                inBeat.data = row.vec[b];
                inBeat.last = (b == nBeats - 1);
                accepted = 1'b0;
                waitCycles = 0;
                while (!accepted && waitCycles < TIMEOUT) begin
                    accepted = inReady;
                    @(posedge clk);
                    #1;
                    waitCycles++;
                end
                if (!accepted) begin
                    $display("timeout: beat %0d of window %0d never accepted", b, w);
                    errorCount++;
                    timedOut = 1'b1;
                    inValid = 1'b0;
                    return;
                end
            end
            lastEdge[w] = edgeCount;
            expQ.push_back(maxOfWindow(row));
        end
        inValid = 1'b0;
        inBeat = '0;
    endtask

    task automatic collectResults();
        featVec_t expVec;
        featVec_t gotVec;
        featVec_t prevVec;
        logic     prevValid;
        logic     prevReady;
        logic     got;
        int       waitCycles;
        int       errBefore;
        prevVec = '0;
        prevValid = 1'b0;
        prevReady = 1'b1;
        for (int r = 0; r < NUM_WIN; r++) begin
            errBefore = errorCount;
            got = 1'b0;
            gotVec = '0;
            waitCycles = 0;
            while (!got && waitCycles < TIMEOUT) begin
                if (winTable[r].stall) begin
                    rngOut = xorshift32(rngOut);
                    outReady = rngOut[0];
                end else begin
                    outReady = 1'b1;
                end
                // Stalled head must not move
                if (prevValid && !prevReady) begin
                    checkLogic("outValid", 1'b1, outValid);
                    checkVec("outVec", prevVec, outVec);
                end
                prevValid = outValid;
                prevReady = outReady;
                prevVec = outVec;
                got = outValid && outReady;
                gotVec = outVec;
                @(posedge clk);
                #1;
                waitCycles++;
            end
            if (!got) begin
                $display("timeout: no pooled result for window %0d", r);
                errorCount++;
                timedOut = 1'b1;
                return;
            end
            if (expQ.size() == 0) begin
                $display("pooled result arrived with no window pending");
                errorCount++;
            end else begin
                expVec = expQ.pop_front();
                checkVec("outVec", expVec, gotVec);
            end
            // Two edges from last beat to output transfer
            if (!winTable[r].stall) begin
                checkCycles("outLatency", 2, edgeCount - lastEdge[r]);
            end
            reportTest($sformatf("window %0d", r), errBefore);
        end
        outReady = 1'b1;
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        int errBefore;
        int waitCycles;
        rst_n = 1'b0;
        inValid = 1'b0;
        inBeat = '0;
        outReady = 1'b0;
        rngIn = SEED;
        rngOut = ~SEED;
        buildTable();

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        errBefore = errorCount;
        checkLogic("outValid", 1'b0, outValid);
        checkLogic("inReady", 1'b0, inReady);
        waitCycles = 0;
        while (!inReady && waitCycles < RESET_WAIT) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        if (!inReady) begin
            $display("timeout: inReady never rose after reset");
            errorCount++;
            timedOut = 1'b1;
        end
        reportTest("reset", errBefore);

        if (!timedOut) begin
            fork
                driveWindows();
                collectResults();
            join
        end

        // Nothing extra may come out
        if (!timedOut) begin
            errBefore = errorCount;
            outReady = 1'b1;
            repeat (6) begin
                @(posedge clk);
                #1;
                checkLogic("outValid", 1'b0, outValid);
            end
            checkCycles("pendingWindows", 0, expQ.size());
            reportTest("drain", errBefore);
        end

        $display("tests %0d, tests with errors %0d, check errors %0d",
                 testsRun, testsBad, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
poolPkg.sv
maxPoolCore.sv
pooledSkidBuffer.sv
maxPoolTop.sv
maxPool_properties.sv
tbMaxPool.sv

// File: runSim.sh
#!/bin/sh
# Compile and run the max pooling testbench with Verilator

LOG=sim.log
BUILD=obj_dir
BIN=simMaxPool

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tbMaxPool \
    -f vlog.f \
    -Mdir "$BUILD" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile step returned an error"
    exit 1
fi

"./$BUILD/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "testbench reported failure, see $LOG"
    exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi

echo "simulation finished without errors"
exit 0
